// ==== include/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// lanes served by one warp instruction
`define LSU_NUM_LANES 4

// data and address width
`define LSU_XLEN 32

`define LSU_RD_BITS 5

`define LSU_WID_BITS 2

`endif

// ==== source/lsu_op_pkg.sv ====
`include "lsu_settings.svh"

package lsu_op_pkg;

    // access size, as encoded by the decoder
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    // one bit per lane of the warp
    typedef logic [`LSU_NUM_LANES-1:0] lane_mask_t;

    typedef logic [`LSU_WID_BITS-1:0] wid_t;

    typedef logic [`LSU_RD_BITS-1:0] rd_t;

    // register operand and result value
    typedef logic [`LSU_XLEN-1:0] reg_data_t;

endpackage

// ==== source/lsu_mem_pkg.sv ====
`include "lsu_settings.svh"

package lsu_mem_pkg;

    localparam int BYTES_PER_WORD = `LSU_XLEN / 8;

    // one bus word, seen as bytes or as halfwords
    typedef union packed {
        logic [BYTES_PER_WORD-1:0][7:0]    bytes;
        logic [BYTES_PER_WORD/2-1:0][15:0] halves;
    } lane_word_t;

    typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

    // byte address with the two offset bits dropped
    typedef logic [`LSU_XLEN-3:0] word_addr_t;

    typedef logic [1:0] align_t;

endpackage

// ==== source/lsu_addr_stage.sv ====
`include "lsu_settings.svh"

module lsu_addr_stage (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           in_valid,
    output logic                                           in_ready,
    input  lsu_op_pkg::wid_t                               wid,
    input  lsu_op_pkg::lane_mask_t                         tmask,
    input  logic                                           is_store,
    input  lsu_op_pkg::size_e                              size,
    input  logic                                           is_unsigned,
    input  lsu_op_pkg::rd_t                                rd,
    input  lsu_op_pkg::reg_data_t [`LSU_NUM_LANES-1:0]     rs1_data,
    input  lsu_op_pkg::reg_data_t [`LSU_NUM_LANES-1:0]     rs2_data,
    input  lsu_op_pkg::reg_data_t                          imm,
    output logic                                           out_valid,
    input  logic                                           out_ready,
    output lsu_op_pkg::wid_t                               out_wid,
    output lsu_op_pkg::lane_mask_t                         out_tmask,
    output logic                                           out_is_store,
    output lsu_op_pkg::size_e                              out_size,
    output logic                                           out_is_unsigned,
    output lsu_op_pkg::rd_t                                out_rd,
    output lsu_mem_pkg::word_addr_t [`LSU_NUM_LANES-1:0]   out_addr,
    output lsu_mem_pkg::align_t [`LSU_NUM_LANES-1:0]       out_align,
    output lsu_mem_pkg::byte_en_t [`LSU_NUM_LANES-1:0]     out_sel,
    output lsu_op_pkg::reg_data_t [`LSU_NUM_LANES-1:0]     out_wdata
);
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    localparam int NUM_LANES = `LSU_NUM_LANES;

    reg_data_t [NUM_LANES-1:0]  full_addr;
    word_addr_t [NUM_LANES-1:0] lane_addr;
    align_t [NUM_LANES-1:0]     lane_align;
    byte_en_t [NUM_LANES-1:0]   lane_sel;
    reg_data_t [NUM_LANES-1:0]  lane_wdata;
    logic                       running;
    logic                       accept;

    // held off until the first cycle out of reset
    assign in_ready = running & (~out_valid | out_ready);
    assign accept = in_valid & in_ready;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            full_addr[i] = rs1_data[i] + imm;
            lane_addr[i] = full_addr[i][`LSU_XLEN-1:2];
            lane_align[i] = full_addr[i][1:0];
            case (size)
                SIZE_BYTE: lane_sel[i] = byte_en_t'(1) << lane_align[i];
                SIZE_HALF: lane_sel[i] = byte_en_t'(3) << {lane_align[i][1], 1'b0};
                default:   lane_sel[i] = '1;
            endcase
            // move store data up into the addressed byte lanes
            lane_wdata[i] = rs2_data[i] << {lane_align[i], 3'b000};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            if (accept) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_wid <= wid;
            out_tmask <= tmask;
            out_is_store <= is_store;
            out_size <= size;
            out_is_unsigned <= is_unsigned;
            out_rd <= rd;
            out_addr <= lane_addr;
            out_align <= lane_align;
            out_sel <= lane_sel;
            out_wdata <= lane_wdata;
        end
    end

endmodule

// ==== source/lsu_lane_sched.sv ====
`include "lsu_settings.svh"

module lsu_lane_sched (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           in_valid,
    output logic                                           in_ready,
    input  lsu_op_pkg::wid_t                               in_wid,
    input  lsu_op_pkg::lane_mask_t                         in_tmask,
    input  logic                                           in_is_store,
    input  lsu_op_pkg::size_e                              in_size,
    input  logic                                           in_is_unsigned,
    input  lsu_op_pkg::rd_t                                in_rd,
    input  lsu_mem_pkg::word_addr_t [`LSU_NUM_LANES-1:0]   in_addr,
    input  lsu_mem_pkg::align_t [`LSU_NUM_LANES-1:0]       in_align,
    input  lsu_mem_pkg::byte_en_t [`LSU_NUM_LANES-1:0]     in_sel,
    input  lsu_op_pkg::reg_data_t [`LSU_NUM_LANES-1:0]     in_wdata,
    output logic                                           wb_cyc,
    output logic                                           wb_stb,
    output logic                                           wb_we,
    output lsu_mem_pkg::word_addr_t                        wb_adr,
    output lsu_mem_pkg::byte_en_t                          wb_sel,
    output lsu_op_pkg::reg_data_t                          wb_dat_w,
    input  lsu_op_pkg::reg_data_t                          wb_dat_r,
    input  logic                                           wb_ack,
    output logic                                           out_valid,
    input  logic                                           out_ready,
    output lsu_op_pkg::wid_t                               out_wid,
    output lsu_op_pkg::lane_mask_t                         out_tmask,
    output logic                                           out_is_store,
    output lsu_op_pkg::size_e                              out_size,
    output logic                                           out_is_unsigned,
    output lsu_op_pkg::rd_t                                out_rd,
    output lsu_mem_pkg::align_t [`LSU_NUM_LANES-1:0]       out_align,
    output lsu_mem_pkg::lane_word_t [`LSU_NUM_LANES-1:0]   out_rdata
);
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    localparam int NUM_LANES = `LSU_NUM_LANES;
    localparam int LANE_BITS = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic                       busy;
    logic                       cyc;
    lane_mask_t                 pending;
    lane_mask_t                 pending_next;
    logic [LANE_BITS-1:0]       cur;
    word_addr_t [NUM_LANES-1:0] addr_q;
    byte_en_t [NUM_LANES-1:0]   sel_q;
    reg_data_t [NUM_LANES-1:0]  wdata_q;
    logic                       accept;
    logic                       bus_done;

    assign in_ready = ~busy;
    assign accept = in_valid & ~busy;
    assign bus_done = cyc & wb_ack;

    // lowest pending lane goes out next
    always_comb begin
        cur = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (pending[i]) begin
                cur = LANE_BITS'(i);
            end
        end
    end

    always_comb begin
        pending_next = pending;
        pending_next[cur] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cyc <= 1'b0;
            pending <= '0;
            out_valid <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
            pending <= in_tmask;
            cyc <= |in_tmask;
            out_valid <= ~|in_tmask;
        end else if (bus_done) begin
            // cyc drops for one cycle between lanes
            cyc <= 1'b0;
            pending <= pending_next;
            out_valid <= ~|pending_next;
        end else if (busy && !cyc && pending != '0) begin
            cyc <= 1'b1;
        end else if (out_valid && out_ready) begin
            busy <= 1'b0;
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_wid <= in_wid;
            out_tmask <= in_tmask;
            out_is_store <= in_is_store;
            out_size <= in_size;
            out_is_unsigned <= in_is_unsigned;
            out_rd <= in_rd;
            out_align <= in_align;
            addr_q <= in_addr;
            sel_q <= in_sel;
            wdata_q <= in_wdata;
        end
        if (bus_done) begin
            out_rdata[cur] <= wb_dat_r;
        end
    end

    assign wb_cyc = cyc;
    assign wb_stb = cyc;
    assign wb_we = cyc & out_is_store;
    assign wb_adr = addr_q[cur];
    assign wb_sel = sel_q[cur];
    assign wb_dat_w = wdata_q[cur];

endmodule

// ==== source/lsu_rsp_stage.sv ====
`include "lsu_settings.svh"

module lsu_rsp_stage (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           in_valid,
    output logic                                           in_ready,
    input  lsu_op_pkg::wid_t                               in_wid,
    input  lsu_op_pkg::lane_mask_t                         in_tmask,
    input  logic                                           in_is_store,
    input  lsu_op_pkg::size_e                              in_size,
    input  logic                                           in_is_unsigned,
    input  lsu_op_pkg::rd_t                                in_rd,
    input  lsu_mem_pkg::align_t [`LSU_NUM_LANES-1:0]       in_align,
    input  lsu_mem_pkg::lane_word_t [`LSU_NUM_LANES-1:0]   in_rdata,
    output logic                                           commit_valid,
    input  logic                                           commit_ready,
    output lsu_op_pkg::wid_t                               commit_wid,
    output lsu_op_pkg::lane_mask_t                         commit_tmask,
    output lsu_op_pkg::rd_t                                commit_rd,
    output logic                                           commit_wb,
    output lsu_op_pkg::reg_data_t [`LSU_NUM_LANES-1:0]     commit_data
);
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    localparam int NUM_LANES = `LSU_NUM_LANES;
    localparam int XLEN = `LSU_XLEN;

    logic [NUM_LANES-1:0][15:0] lane_half;
    logic [NUM_LANES-1:0][7:0]  lane_byte;
    reg_data_t [NUM_LANES-1:0]  lane_data;
    logic                       accept;

    assign in_ready = ~commit_valid | commit_ready;
    assign accept = in_valid & in_ready;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_half[i] = in_rdata[i].halves[in_align[i][1]];
            lane_byte[i] = in_rdata[i].bytes[in_align[i]];
            case (in_size)
                SIZE_BYTE: lane_data[i] = {{(XLEN-8){~in_is_unsigned & lane_byte[i][7]}},
                                           lane_byte[i]};
                SIZE_HALF: lane_data[i] = {{(XLEN-16){~in_is_unsigned & lane_half[i][15]}},
                                           lane_half[i]};
                default:   lane_data[i] = in_rdata[i];
            endcase
            // stores write nothing back
            if (in_is_store) begin
                lane_data[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else if (accept) begin
            commit_valid <= 1'b1;
        end else if (commit_ready) begin
            commit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            commit_wid <= in_wid;
            commit_tmask <= in_tmask;
            commit_rd <= in_rd;
            commit_wb <= ~in_is_store;
            commit_data <= lane_data;
        end
    end

endmodule

// ==== source/lsu_top.sv ====
`include "lsu_settings.svh"

module lsu_top (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           dispatch_valid,
    output logic                                           dispatch_ready,
    input  lsu_op_pkg::wid_t                               wid,
    input  lsu_op_pkg::lane_mask_t                         tmask,
    input  logic                                           is_store,
    input  lsu_op_pkg::size_e                              size,
    input  logic                                           is_unsigned,
    input  lsu_op_pkg::rd_t                                rd,
    input  lsu_op_pkg::reg_data_t [`LSU_NUM_LANES-1:0]     rs1_data,
    input  lsu_op_pkg::reg_data_t [`LSU_NUM_LANES-1:0]     rs2_data,
    input  lsu_op_pkg::reg_data_t                          imm,
    output logic                                           commit_valid,
    input  logic                                           commit_ready,
    output lsu_op_pkg::wid_t                               commit_wid,
    output lsu_op_pkg::lane_mask_t                         commit_tmask,
    output lsu_op_pkg::rd_t                                commit_rd,
    output logic                                           commit_wb,
    output lsu_op_pkg::reg_data_t [`LSU_NUM_LANES-1:0]     commit_data,
    output logic                                           wb_cyc,
    output logic                                           wb_stb,
    output logic                                           wb_we,
    output lsu_mem_pkg::word_addr_t                        wb_adr,
    output lsu_mem_pkg::byte_en_t                          wb_sel,
    output lsu_op_pkg::reg_data_t                          wb_dat_w,
    input  lsu_op_pkg::reg_data_t                          wb_dat_r,
    input  logic                                           wb_ack
);
    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    localparam int NUM_LANES = `LSU_NUM_LANES;

    // address stage to scheduler
    logic                       a_valid;
    logic                       a_ready;
    wid_t                       a_wid;
    lane_mask_t                 a_tmask;
    logic                       a_is_store;
    size_e                      a_size;
    logic                       a_is_unsigned;
    rd_t                        a_rd;
    word_addr_t [NUM_LANES-1:0] a_addr;
    align_t [NUM_LANES-1:0]     a_align;
    byte_en_t [NUM_LANES-1:0]   a_sel;
    reg_data_t [NUM_LANES-1:0]  a_wdata;

    // scheduler to response stage
    logic                       s_valid;
    logic                       s_ready;
    wid_t                       s_wid;
    lane_mask_t                 s_tmask;
    logic                       s_is_store;
    size_e                      s_size;
    logic                       s_is_unsigned;
    rd_t                        s_rd;
    align_t [NUM_LANES-1:0]     s_align;
    lane_word_t [NUM_LANES-1:0] s_rdata;

    lsu_addr_stage addr_stage (
        .clk(clk), .reset(reset),
        .in_valid(dispatch_valid), .in_ready(dispatch_ready),
        .wid(wid), .tmask(tmask), .is_store(is_store), .size(size),
        .is_unsigned(is_unsigned), .rd(rd),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .out_valid(a_valid), .out_ready(a_ready),
        .out_wid(a_wid), .out_tmask(a_tmask), .out_is_store(a_is_store),
        .out_size(a_size), .out_is_unsigned(a_is_unsigned), .out_rd(a_rd),
        .out_addr(a_addr), .out_align(a_align), .out_sel(a_sel), .out_wdata(a_wdata)
    );

    lsu_lane_sched lane_sched (
        .clk(clk), .reset(reset),
        .in_valid(a_valid), .in_ready(a_ready),
        .in_wid(a_wid), .in_tmask(a_tmask), .in_is_store(a_is_store),
        .in_size(a_size), .in_is_unsigned(a_is_unsigned), .in_rd(a_rd),
        .in_addr(a_addr), .in_align(a_align), .in_sel(a_sel), .in_wdata(a_wdata),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .out_valid(s_valid), .out_ready(s_ready),
        .out_wid(s_wid), .out_tmask(s_tmask), .out_is_store(s_is_store),
        .out_size(s_size), .out_is_unsigned(s_is_unsigned), .out_rd(s_rd),
        .out_align(s_align), .out_rdata(s_rdata)
    );

    lsu_rsp_stage rsp_stage (
        .clk(clk), .reset(reset),
        .in_valid(s_valid), .in_ready(s_ready),
        .in_wid(s_wid), .in_tmask(s_tmask), .in_is_store(s_is_store),
        .in_size(s_size), .in_is_unsigned(s_is_unsigned), .in_rd(s_rd),
        .in_align(s_align), .in_rdata(s_rdata),
        .commit_valid(commit_valid), .commit_ready(commit_ready),
        .commit_wid(commit_wid), .commit_tmask(commit_tmask), .commit_rd(commit_rd),
        .commit_wb(commit_wb), .commit_data(commit_data)
    );

endmodule

// ==== sim/lsu_clk_gen.sv ====
module lsu_clk_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // synchronous reset held over the first 16 rising edges
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== sim/lsu_wb_mem.sv ====
`include "lsu_settings.svh"

module lsu_wb_mem #(
    parameter int DEPTH = 64
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  lsu_mem_pkg::word_addr_t adr,
    input  lsu_mem_pkg::byte_en_t   sel,
    input  lsu_op_pkg::reg_data_t   dat_w,
    output lsu_op_pkg::reg_data_t   dat_r,
    output logic                    ack
);
    timeunit 1ns;
    timeprecision 100ps;

    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    localparam int AW = $clog2(DEPTH);

    reg_data_t  mem_words [DEPTH];
    logic       waiting;
    logic [1:0] wait_left;

    // odd multiplier, so every address bit shows in the fill
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem_words[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
        end
    end

    always @(posedge clk) begin
        logic [1:0] left;
        reg_data_t  merged;
        if (reset) begin
            ack <= 1'b0;
            waiting <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                // wait count drawn once per strobe
                left = waiting ? wait_left : 2'($urandom_range(0, 3));
                if (left == 2'd0) begin
                    ack <= 1'b1;
                    waiting <= 1'b0;
                    dat_r <= mem_words[adr[AW-1:0]];
                    merged = mem_words[adr[AW-1:0]];
                    for (int b = 0; b < BYTES_PER_WORD; b++) begin
                        if (sel[b]) begin
                            merged[8*b +: 8] = dat_w[8*b +: 8];
                        end
                    end
                    if (we) begin
                        mem_words[adr[AW-1:0]] <= merged;
                    end
                end else begin
                    waiting <= 1'b1;
                    wait_left <= left - 2'd1;
                end
            end
        end
    end

endmodule

// ==== sim/lsu_tb.sv ====
`include "lsu_settings.svh"

module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import lsu_op_pkg::*;
    import lsu_mem_pkg::*;

    localparam int NUM_LANES = `LSU_NUM_LANES;
    localparam int XLEN = `LSU_XLEN;
    localparam int NUM_OPS = 200;
    localparam int MEM_WORDS = 64;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLE_LIMIT = NUM_OPS * NUM_LANES * 5 + RESET_CYCLES + 500;
    // three instructions in flight at most
    localparam int DRAIN_LIMIT = 3 * NUM_LANES * 5 + 100;
    localparam logic [31:0] SEED = 32'heee6_19b7;

    typedef struct packed {
        wid_t                      wid;
        lane_mask_t                tmask;
        rd_t                       rd;
        logic                      wb;
        reg_data_t [NUM_LANES-1:0] data;
    } commit_rec_t;

    // one expected Wishbone cycle, tagged with its instruction number
    typedef struct packed {
        int         op;
        word_addr_t adr;
        logic       we;
        byte_en_t   sel;
        reg_data_t  dat;
    } bus_exp_t;

    logic                      clk;
    logic                      reset;
    logic                      dispatch_valid;
    logic                      dispatch_ready;
    wid_t                      wid;
    lane_mask_t                tmask;
    logic                      is_store;
    size_e                     size;
    logic                      is_unsigned;
    rd_t                       rd;
    reg_data_t [NUM_LANES-1:0] rs1_data;
    reg_data_t [NUM_LANES-1:0] rs2_data;
    reg_data_t                 imm;
    logic                      commit_valid;
    logic                      commit_ready;
    wid_t                      commit_wid;
    lane_mask_t                commit_tmask;
    rd_t                       commit_rd;
    logic                      commit_wb;
    reg_data_t [NUM_LANES-1:0] commit_data;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    word_addr_t                wb_adr;
    byte_en_t                  wb_sel;
    reg_data_t                 wb_dat_w;
    reg_data_t                 wb_dat_r;
    logic                      wb_ack;

    reg_data_t   shadow [MEM_WORDS];
    commit_rec_t exp_q[$];
    int          exp_op_q[$];
    bus_exp_t    bus_q[$];
    commit_rec_t live;
    commit_rec_t held;
    bus_exp_t    req;
    bus_exp_t    req_q;
    logic        hold_q = 1'b0;
    logic        bus_open = 1'b0;
    logic        acked_q = 1'b0;
    logic [1:0]  reset_hist = 2'b00;
    int          drain = 0;
    int          cycles = 0;

    lsu_clk_gen clk_gen (.clk(clk), .reset(reset));

    lsu_top dut (
        .clk(clk), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_ready(dispatch_ready),
        .wid(wid), .tmask(tmask), .is_store(is_store), .size(size),
        .is_unsigned(is_unsigned), .rd(rd),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .commit_valid(commit_valid), .commit_ready(commit_ready),
        .commit_wid(commit_wid), .commit_tmask(commit_tmask), .commit_rd(commit_rd),
        .commit_wb(commit_wb), .commit_data(commit_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    lsu_wb_mem #(.DEPTH(MEM_WORDS)) memory (
        .clk(clk), .reset(reset), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we),
        .adr(wb_adr), .sel(wb_sel), .dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack)
    );

    assign live = {commit_wid, commit_tmask, commit_rd, commit_wb, commit_data};
    assign req = {32'd0, wb_adr, wb_we, wb_sel, wb_dat_w};

    task automatic report_mismatch(input string msg);
        $display("[FAIL] t=%0t %s", $time, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic drive_random_op(input int k);
        reg_data_t [NUM_LANES-1:0] base;
        reg_data_t [NUM_LANES-1:0] data;
        reg_data_t                 offs;
        reg_data_t                 target;
        size_e                     sz;
        logic [1:0]                off;
        sz = size_e'($urandom_range(0, 2));
        offs = $urandom;
        for (int i = 0; i < NUM_LANES; i++) begin
            off = 2'($urandom);
            if (sz == SIZE_HALF) begin
                off[0] = 1'b0;
            end else if (sz == SIZE_WORD) begin
                off = 2'd0;
            end
            target = (reg_data_t'($urandom_range(0, MEM_WORDS - 1)) << 2) | reg_data_t'(off);
            // base chosen so that base plus immediate lands on the target
            base[i] = target - offs;
            data[i] = $urandom;
        end
        if (k % 20 == 0) begin
            tmask <= '0;
        end else if (k % 20 == 1) begin
            tmask <= '1;
        end else begin
            tmask <= lane_mask_t'($urandom);
        end
        dispatch_valid <= 1'b1;
        wid <= wid_t'($urandom);
        rd <= rd_t'($urandom);
        is_store <= 1'($urandom);
        is_unsigned <= 1'($urandom);
        size <= sz;
        imm <= offs;
        rs1_data <= base;
        rs2_data <= data;
    endtask

    // shadow memory and expected records, in dispatch order
    task automatic record_dispatch(input int k);
        commit_rec_t c;
        bus_exp_t    b;
        reg_data_t   addr;
        reg_data_t   word;
        int          w;
        int          sh;
        c = {wid, tmask, rd, ~is_store, {(NUM_LANES * XLEN){1'b0}}};
        for (int i = 0; i < NUM_LANES; i++) begin
            if (tmask[i]) begin
                addr = rs1_data[i] + imm;
                w = int'(addr[XLEN-1:2]);
                sh = int'(addr[1:0]) * 8;
                b.op = k;
                b.adr = addr[XLEN-1:2];
                b.we = is_store;
                case (size)
                    SIZE_BYTE: b.sel = byte_en_t'(1) << addr[1:0];
                    SIZE_HALF: b.sel = byte_en_t'(3) << addr[1:0];
                    default:   b.sel = '1;
                endcase
                b.dat = rs2_data[i] << sh;
                bus_q.push_back(b);
                if (is_store) begin
                    for (int j = 0; j < XLEN / 8; j++) begin
                        if (b.sel[j]) begin
                            shadow[w][8*j +: 8] = b.dat[8*j +: 8];
                        end
                    end
                end else begin
                    word = shadow[w] >> sh;
                    case (size)
                        SIZE_BYTE: c.data[i] = {{(XLEN-8){~is_unsigned & word[7]}}, word[7:0]};
                        SIZE_HALF: c.data[i] = {{(XLEN-16){~is_unsigned & word[15]}}, word[15:0]};
                        default:   c.data[i] = word;
                    endcase
                end
            end
        end
        exp_q.push_back(c);
        exp_op_q.push_back(k);
    endtask

    initial begin
        void'($urandom(SEED));
        dispatch_valid <= 1'b0;
        wid <= '0;
        tmask <= '0;
        is_store <= 1'b0;
        size <= SIZE_WORD;
        is_unsigned <= 1'b0;
        rd <= '0;
        rs1_data <= '0;
        rs2_data <= '0;
        imm <= '0;
        commit_ready <= 1'b0;
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = memory.mem_words[i];
        end
        for (int k = 0; k < NUM_OPS; k++) begin
            drive_random_op(k);
            @(posedge clk);
            while (!dispatch_ready) begin
                @(posedge clk);
            end
            record_dispatch(k);
        end
        dispatch_valid <= 1'b0;
        while (exp_q.size() != 0 && drain < DRAIN_LIMIT) begin
            @(posedge clk);
            drain++;
        end
        // a few idle cycles to catch a stray commit or bus cycle
        repeat (20) @(posedge clk);
        if (exp_q.size() != 0 || bus_q.size() != 0) begin
            abort_run($sformatf("%0d commits and %0d lane accesses never happened",
                                exp_q.size(), bus_q.size()));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

    always @(posedge clk) begin
        commit_ready <= ($urandom_range(0, 3) != 0);
    end

    always @(posedge clk) begin
        reset_hist <= {reset_hist[0], reset};
        if (reset_hist != 2'b00) begin
            assert (!commit_valid && !wb_cyc && !wb_stb)
                else report_mismatch("commit_valid or bus strobe high around reset");
        end
    end

    always @(posedge clk) begin
        bus_exp_t e;
        if (!reset) begin
            assert (wb_cyc == wb_stb) else report_mismatch("wb_cyc and wb_stb differ");
            if (acked_q) begin
                assert (!wb_cyc) else report_mismatch("wb_cyc still high the cycle after ack");
            end
            if (bus_open) begin
                assert (wb_cyc && req == req_q)
                    else report_mismatch("bus request dropped or changed before ack");
            end else if (wb_cyc) begin
                if (bus_q.size() == 0) begin
                    abort_run("a bus cycle started with no active lane waiting for one");
                end else begin
                    e = bus_q.pop_front();
                    assert (wb_adr == e.adr && wb_we == e.we)
                        else report_mismatch($sformatf("op %0d adr %h we %b, expected %h %b",
                                                       e.op, wb_adr, wb_we, e.adr, e.we));
                    assert (wb_sel == e.sel)
                        else report_mismatch($sformatf("op %0d wb_sel %b, expected %b",
                                                       e.op, wb_sel, e.sel));
                    assert (!e.we || wb_dat_w == e.dat)
                        else report_mismatch($sformatf("op %0d wb_dat_w %h, expected %h",
                                                       e.op, wb_dat_w, e.dat));
                end
            end
        end
        bus_open <= !reset && wb_cyc && !wb_ack;
        acked_q <= !reset && wb_cyc && wb_ack;
        req_q <= req;
    end

    always @(posedge clk) begin
        commit_rec_t e;
        int          op;
        if (!reset) begin
            if (hold_q) begin
                assert (commit_valid && live == held)
                    else report_mismatch("commit record changed while commit_ready was low");
            end
            if (commit_valid && commit_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("a commit arrived with no instruction outstanding");
                end else begin
                    e = exp_q.pop_front();
                    op = exp_op_q.pop_front();
                    assert (live.wid == e.wid && live.tmask == e.tmask &&
                            live.rd == e.rd && live.wb == e.wb)
                        else report_mismatch($sformatf(
                            "op %0d header %h/%b/%0d/%b, expected %h/%b/%0d/%b",
                            op, live.wid, live.tmask, live.rd, live.wb,
                            e.wid, e.tmask, e.rd, e.wb));
                    assert (bus_q.size() == 0 || bus_q[0].op > op)
                        else report_mismatch($sformatf("op %0d committed with lane accesses missing",
                                                       op));
                    for (int i = 0; i < NUM_LANES; i++) begin
                        if (e.wb && e.tmask[i]) begin
                            assert (live.data[i] == e.data[i])
                                else report_mismatch($sformatf("op %0d lane %0d data %h, expected %h",
                                                               op, i, live.data[i], e.data[i]));
                        end
                    end
                end
            end
        end
        hold_q <= !reset && commit_valid && !commit_ready;
        held <= live;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: the run was still going after %0d cycles",
                                CYCLE_LIMIT));
        end
    end

endmodule

// ==== verilog.f ====
+incdir+include
source/lsu_op_pkg.sv
source/lsu_mem_pkg.sv
source/lsu_addr_stage.sv
source/lsu_lane_sched.sv
source/lsu_rsp_stage.sv
source/lsu_top.sv
sim/lsu_clk_gen.sv
sim/lsu_wb_mem.sv
sim/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/lsu_op_pkg.sv
      - source/lsu_mem_pkg.sv
      - source/lsu_addr_stage.sv
      - source/lsu_lane_sched.sv
      - source/lsu_rsp_stage.sv
      - source/lsu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/lsu_clk_gen.sv
      - sim/lsu_wb_mem.sv
      - sim/lsu_tb.sv
